// File: files.f
src/uart_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_bus.sv
src/uart.sv
verification/uart_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the UART testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  -f files.f \
  --top-module uart_tb \
  -o uart_sim

./obj_dir/uart_sim

// File: src/uart.sv
module uart (
  input  logic        clk,
  input  logic        rst,
  input  logic        uart_valid,
  input  logic [31:0] uart_wdata,
  input  logic [3:0]  uart_wstrb,
  input  logic        rx,
  output logic [31:0] uart_rdata,
  output logic        uart_ready,
  output logic        tx
);

  logic       tx_start;
  logic [7:0] tx_byte;
  logic       tx_done;
  logic       rx_valid;
  logic [7:0] rx_byte;

  // ####################
  // Bus side

  uart_bus bus_i (
    .clk        (clk),
    .rst        (rst),
    .uart_valid (uart_valid),
    .uart_wdata (uart_wdata),
    .uart_wstrb (uart_wstrb),
    .tx_done    (tx_done),
    .rx_valid   (rx_valid),
    .rx_byte    (rx_byte),
    .uart_rdata (uart_rdata),
    .uart_ready (uart_ready),
    .tx_start   (tx_start),
    .tx_byte    (tx_byte)
  );

  // ####################
  // Serial side

  uart_tx tx_i (
    .clk      (clk),
    .rst      (rst),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  uart_rx rx_i (
    .clk      (clk),
    .rst      (rst),
    .rx       (rx),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte)
  );

endmodule

// File: src/uart_bus.sv
module uart_bus (
  input  logic        clk,
  input  logic        rst,
  input  logic        uart_valid,
  input  logic [31:0] uart_wdata,
  input  logic [3:0]  uart_wstrb,
  input  logic        tx_done,
  input  logic        rx_valid,
  input  logic [7:0]  rx_byte,
  output logic [31:0] uart_rdata,
  output logic        uart_ready,
  output logic        tx_start,
  output logic [7:0]  tx_byte
);

  uart_pkg::bus_state_t state;

  logic is_write;
  logic accept;

  assign is_write = |uart_wstrb;
  // Valid is still high in the ready cycle
  assign accept   = uart_valid && !uart_ready && (state == uart_pkg::bus_idle);

  // ####################
  // Request phase

  always_ff @(posedge clk) begin
    if (!rst) begin
      state      <= uart_pkg::bus_idle;
      tx_start   <= 1'b0;
      uart_ready <= 1'b0;
      uart_rdata <= '0;
    end else begin
      tx_start   <= 1'b0;
      uart_ready <= 1'b0;
      case (state)
        uart_pkg::bus_idle: begin
          if (accept) begin
            tx_start <= is_write;
            state    <= is_write ? uart_pkg::bus_write : uart_pkg::bus_read;
          end
        end
        uart_pkg::bus_write: begin
          if (tx_done) begin
            uart_ready <= 1'b1;
            state      <= uart_pkg::bus_idle;
          end
        end
        uart_pkg::bus_read: begin
          if (rx_valid) begin
            uart_ready <= 1'b1;
            uart_rdata <= {{(32 - uart_pkg::data_bits){1'b0}}, rx_byte};
            state      <= uart_pkg::bus_idle;
          end
        end
        default: state <= uart_pkg::bus_idle;
      endcase
    end
  end

  // Upper wdata bits are ignored
  always_ff @(posedge clk) begin
    if (accept && is_write) begin
      tx_byte <= uart_wdata[uart_pkg::data_bits-1:0];
    end
  end

endmodule

// File: src/uart_pkg.sv
package uart_pkg;

  // ####################
  // Frame timing

  localparam int bit_cycles  = 8;  // Clocks per serial bit
  localparam int half_cycles = bit_cycles / 2;
  localparam int data_bits   = 8;

  // Counter widths
  localparam int cnt_w = $clog2(bit_cycles);
  localparam int idx_w = $clog2(data_bits);

  localparam logic [cnt_w-1:0] last_cycle = cnt_w'(bit_cycles - 1);
  localparam logic [cnt_w-1:0] half_last  = cnt_w'(half_cycles - 1);
  localparam logic [idx_w-1:0] last_bit   = idx_w'(data_bits - 1);

  // ####################
  // State encodings

  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop
  } tx_state_t;

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,  // Waiting for mid start bit
    rx_data,
    rx_stop
  } rx_state_t;

  typedef enum logic [1:0] {
    bus_idle,
    bus_write,
    bus_read
  } bus_state_t;

endpackage

// File: src/uart_rx.sv
module uart_rx (
  input  logic       clk,
  input  logic       rst,
  input  logic       rx,
  output logic       rx_valid,
  output logic [7:0] rx_byte
);

  uart_pkg::rx_state_t state;

  logic rx_meta;
  logic rx_sync;
  logic rx_prev;
  logic fall;

  logic [uart_pkg::cnt_w-1:0]     cnt;
  logic [uart_pkg::idx_w-1:0]     bit_idx;
  logic [uart_pkg::data_bits-1:0] shreg;
  logic                           bit_end;
  logic                           sample;

  // ####################
  // Synchronizer

  always_ff @(posedge clk) begin
    if (!rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall    = rx_prev & ~rx_sync;
  assign bit_end = (cnt == uart_pkg::last_cycle);
  assign sample  = (state == uart_pkg::rx_data) && bit_end;

  // ####################
  // Control

  always_ff @(posedge clk) begin
    if (!rst) begin
      state    <= uart_pkg::rx_idle;
      cnt      <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        uart_pkg::rx_idle: begin
          cnt <= '0;
          if (fall) begin
            state <= uart_pkg::rx_start;
          end
        end
        uart_pkg::rx_start: begin
          cnt <= cnt + 1'b1;
          if (cnt == uart_pkg::half_last) begin
            cnt <= '0;
            bit_idx <= '0;
            // High at mid start bit is a glitch
            state <= rx_sync ? uart_pkg::rx_idle : uart_pkg::rx_data;
          end
        end
        uart_pkg::rx_data: begin
          cnt <= cnt + 1'b1;
          if (bit_end) begin
            if (bit_idx == uart_pkg::last_bit) begin
              state <= uart_pkg::rx_stop;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end
        uart_pkg::rx_stop: begin
          cnt <= cnt + 1'b1;
          if (bit_end) begin
            rx_valid <= rx_sync;  // Framing error drops the byte
            state    <= uart_pkg::rx_idle;
          end
        end
        default: state <= uart_pkg::rx_idle;
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (sample) begin
      shreg <= {rx_sync, shreg[uart_pkg::data_bits-1:1]};
    end
  end

  assign rx_byte = shreg;

endmodule

// File: src/uart_tx.sv
module uart_tx (
  input  logic       clk,
  input  logic       rst,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx,
  output logic       tx_done
);

  uart_pkg::tx_state_t state;

  logic [uart_pkg::cnt_w-1:0]     cnt;
  logic [uart_pkg::idx_w-1:0]     bit_idx;
  logic [uart_pkg::data_bits-1:0] shreg;
  logic                           bit_end;

  assign bit_end = (cnt == uart_pkg::last_cycle);

  // ####################
  // Control

  always_ff @(posedge clk) begin
    if (!rst) begin
      state   <= uart_pkg::tx_idle;
      cnt     <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
      tx_done <= 1'b0;
    end else begin
      tx_done <= 1'b0;
      case (state)
        uart_pkg::tx_idle: begin
          cnt <= '0;
          tx  <= 1'b1;
          if (tx_start) begin
            tx    <= 1'b0;  // Start bit
            state <= uart_pkg::tx_start;
          end
        end
        uart_pkg::tx_start: begin
          cnt <= cnt + 1'b1;
          if (bit_end) begin
            tx      <= shreg[0];
            bit_idx <= '0;
            state   <= uart_pkg::tx_data;
          end
        end
        uart_pkg::tx_data: begin
          cnt <= cnt + 1'b1;
          if (bit_end) begin
            if (bit_idx == uart_pkg::last_bit) begin
              tx    <= 1'b1;  // Stop bit
              state <= uart_pkg::tx_stop;
            end else begin
              tx      <= shreg[1];
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end
        uart_pkg::tx_stop: begin
          cnt <= cnt + 1'b1;
          if (bit_end) begin
            tx_done <= 1'b1;
            state   <= uart_pkg::tx_idle;
          end
        end
        default: state <= uart_pkg::tx_idle;
      endcase
    end
  end

  // ####################
  // Data shifter

  always_ff @(posedge clk) begin
    if (state == uart_pkg::tx_idle && tx_start) begin
      shreg <= tx_byte;
    end else if (state == uart_pkg::tx_data && bit_end) begin
      shreg <= {1'b1, shreg[uart_pkg::data_bits-1:1]};  // LSB first
    end
  end

endmodule

// File: verification/uart_tb.sv
module uart_tb;

  localparam int num_writes    = 20;
  localparam int num_frames    = 7;  // Frames sent on rx
  localparam int num_transfers = num_writes + 1 + num_frames;
  localparam int timeout       = num_transfers * 12 * uart_pkg::bit_cycles * 4 + 4000;
  localparam int ready_limit   = 40 * uart_pkg::bit_cycles;

  logic        clk = 1'b0;
  logic        rst;
  logic        uart_valid;
  logic [31:0] uart_wdata;
  logic [3:0]  uart_wstrb;
  logic        rx;
  logic [31:0] uart_rdata;
  logic        uart_ready;
  logic        tx;

  logic [7:0] tx_q[$];  // Bytes decoded from the tx line

  always #2 clk = ~clk;

  uart dut_i (
    .clk        (clk),
    .rst        (rst),
    .uart_valid (uart_valid),
    .uart_wdata (uart_wdata),
    .uart_wstrb (uart_wstrb),
    .rx         (rx),
    .uart_rdata (uart_rdata),
    .uart_ready (uart_ready),
    .tx         (tx)
  );

  // ####################
  // Checking

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp));
    end
  endtask

  // ####################
  // Bus side

  task automatic start_request(input logic [31:0] data, input logic [3:0] strb);
    @(posedge clk);
    uart_valid <= 1'b1;
    uart_wdata <= data;
    uart_wstrb <= strb;
  endtask

  // Counts edges until ready shows up
  task automatic wait_ready(output int cycles);
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
    end while (!uart_ready && cycles < ready_limit);
    if (!uart_ready) begin
      abort_run($sformatf("no uart_ready within %0d cycles of the request", ready_limit));
    end
  endtask

  task automatic end_request();
    @(posedge clk);
    uart_valid <= 1'b0;
    uart_wstrb <= 4'h0;
    @(negedge clk);
    compare("uart_ready pulse width", 32'(uart_ready), 32'd0);
  endtask

  task automatic write_byte(input logic [31:0] data, input logic [3:0] strb);
    int         cycles;
    logic [7:0] got;
    start_request(data, strb);
    wait_ready(cycles);
    end_request();
    compare("write latency", 32'(cycles), 32'(10 * uart_pkg::bit_cycles + 3));
    compare("tx frame count", 32'(tx_q.size()), 32'd1);
    got = tx_q.pop_front();
    compare("tx byte", {24'h0, got}, {24'h0, data[7:0]});  // Upper wdata bits ignored
    repeat (2) @(negedge clk);
    compare("tx idle after write", 32'(tx), 32'd1);
  endtask

  // ####################
  // Serial side

  task automatic send_frame(input logic [7:0] data, input logic stop);
    logic [9:0] frame;
    frame = {stop, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      rx <= frame[0];
      frame = frame >> 1;
      repeat (uart_pkg::bit_cycles - 1) @(posedge clk);
    end
    @(posedge clk);
    rx <= 1'b1;
    repeat (2 * uart_pkg::bit_cycles - 1) @(posedge clk);  // Let the receiver finish
  endtask

  // Second frame is sent only after a bad stop bit
  task automatic read_frames(input logic [7:0] first, input logic first_stop,
                             input logic [7:0] second);
    logic [7:0] expected;
    int         cycles;
    int         gap;
    expected = first_stop ? first : second;
    gap = $urandom_range(2 * uart_pkg::bit_cycles, 1);
    start_request(32'($urandom), 4'h0);
    fork
      begin
        repeat (gap) @(posedge clk);
        send_frame(first, first_stop);
        if (!first_stop) begin
          send_frame(second, 1'b1);
        end
      end
      begin
        wait_ready(cycles);
        end_request();
      end
    join
    compare("uart_rdata", uart_rdata, {24'h0, expected});
    repeat (uart_pkg::bit_cycles) @(negedge clk);
    compare("uart_rdata held", uart_rdata, {24'h0, expected});
    compare("uart_ready after read", 32'(uart_ready), 32'd0);
  endtask

  initial begin : tx_monitor
    logic       prev;
    logic [7:0] shifted;
    prev = 1'b1;
    forever begin
      @(negedge clk);
      if (prev && !tx) begin
        repeat (uart_pkg::bit_cycles / 2) @(negedge clk);  // Mid start bit
        compare("tx start bit", 32'(tx), 32'd0);
        for (int i = 0; i < uart_pkg::data_bits; i++) begin
          repeat (uart_pkg::bit_cycles) @(negedge clk);
          shifted = {tx, shifted[7:1]};
        end
        repeat (uart_pkg::bit_cycles) @(negedge clk);
        compare("tx stop bit", 32'(tx), 32'd1);
        tx_q.push_back(shifted);
      end
      prev = tx;
    end
  end

  initial begin : watchdog
    #(timeout);
    abort_run($sformatf("timeout, run still going after %0d time units", timeout));
  end

  // ####################
  // Stimulus

  initial begin : stimulus
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] c;
    rst        = 1'b0;
    uart_valid = 1'b0;
    uart_wdata = '0;
    uart_wstrb = '0;
    rx         = 1'b1;
    void'($urandom(32'hafed));

    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      if (i == 2) rst <= 1'b1;
      @(negedge clk);
      compare("uart_ready in reset", 32'(uart_ready), 32'd0);
      compare("tx in reset", 32'(tx), 32'd1);
      compare("uart_rdata in reset", uart_rdata, 32'd0);
    end
    repeat (2) @(negedge clk);
    compare("uart_ready after reset", 32'(uart_ready), 32'd0);
    compare("tx after reset", 32'(tx), 32'd1);
    compare("uart_rdata after reset", uart_rdata, 32'd0);

    for (int n = 0; n < num_writes; n++) begin
      write_byte(32'($urandom), 4'($urandom_range(15, 1)));
      repeat ($urandom_range(3, 0)) @(posedge clk);
    end

    a = 8'($urandom);
    read_frames(a, 1'b1, 8'h00);

    // Byte sent with no read pending is lost
    b = a + 8'($urandom_range(255, 1));
    send_frame(b, 1'b1);
    @(negedge clk);
    compare("uart_rdata after dropped byte", uart_rdata, {24'h0, a});
    c = b + 8'($urandom_range(255, 1));
    read_frames(c, 1'b1, 8'h00);

    a = 8'($urandom);
    b = a + 8'($urandom_range(255, 1));
    read_frames(a, 1'b0, b);  // Framing error on the first frame

    a = 8'($urandom);
    b = a + 8'($urandom_range(255, 1));
    c = b + 8'($urandom_range(255, 1));
    fork
      write_byte({24'($urandom), a}, 4'h1);
      send_frame(b, 1'b1);
    join
    read_frames(c, 1'b1, 8'h00);

    @(negedge clk);
    compare("unexpected tx frames", 32'(tx_q.size()), 32'd0);
    $display("all tests passed");
    $finish;
  end

endmodule
